// File: all.f
design/core_pkg.sv
design/inst_decoder.sv
design/rename_table.sv
design/phys_regfile.sv
design/reservation_station.sv
design/exec_unit.sv
design/reorder_buffer.sv
design/ooo_core.sv
test/ooo_core_tb.sv

// File: design/core_pkg.sv
////////////////////////////////////////////////////////////
// core package: sizes, opcodes, execute ops and the
// instruction word with its register and immediate views
////////////////////////////////////////////////////////////

package core_pkg;

  // architectural and physical register spaces
  localparam int arch_regs   = 8;
  localparam int arch_idx_w  = 3;
  localparam int phys_regs   = 16;
  localparam int phys_idx_w  = 4;
  localparam int free_depth  = phys_regs - arch_regs;  // tags not mapped at any time
  localparam int free_idx_w  = 3;
  localparam int free_cnt_w  = 4;

  // window sizes
  localparam int rob_depth   = 8;
  localparam int rob_idx_w   = 3;
  localparam int rob_cnt_w   = 4;
  localparam int rs_depth    = 4;
  localparam int rs_idx_w    = 2;
  localparam int rs_cnt_w    = 3;

  localparam int data_w      = 32;
  localparam int imm_w       = 16;
  localparam int mul_latency = 3;   // issue to result bus

  // instruction opcodes
  localparam logic [2:0] op_add  = 3'd0;
  localparam logic [2:0] op_sub  = 3'd1;
  localparam logic [2:0] op_and  = 3'd2;
  localparam logic [2:0] op_xor  = 3'd3;
  localparam logic [2:0] op_addi = 3'd4;
  localparam logic [2:0] op_xori = 3'd5;
  localparam logic [2:0] op_mul  = 3'd6;

  typedef enum logic [2:0] {
    exec_add,
    exec_sub,
    exec_and,
    exec_xor,
    exec_mul
  } exec_op_e;

  // same 32 bits, two formats
  typedef union packed {
    struct packed {
      logic [2:0]            opcode;
      logic [arch_idx_w-1:0] dest;
      logic [arch_idx_w-1:0] src1;
      logic [arch_idx_w-1:0] src2;
      logic [19:0]           unused;
    } rtype;
    struct packed {
      logic [2:0]            opcode;
      logic [arch_idx_w-1:0] dest;
      logic [arch_idx_w-1:0] src1;
      logic [6:0]            unused;
      logic [imm_w-1:0]      imm;     // signed
    } itype;
  } inst_word_u;

endpackage

// File: design/exec_unit.sv
////////////////////////////////////////////////////////////
// execute unit: one-cycle ALU and three-stage multiplier
// sharing the result bus
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module exec_unit import core_pkg::*; (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  issue_valid,
  input  exec_op_e              issue_op,
  input  logic [data_w-1:0]     issue_a,
  input  logic [data_w-1:0]     issue_b,
  input  logic [phys_idx_w-1:0] issue_tag,
  input  logic [rob_idx_w-1:0]  issue_rob,
  output logic                  issue_ok,
  output logic                  res_valid,
  output logic [phys_idx_w-1:0] res_tag,
  output logic [data_w-1:0]     res_data,
  output logic [rob_idx_w-1:0]  res_rob
);

  logic                   is_mul, alu_v;
  logic [data_w-1:0]      alu_out, alu_data;
  logic [phys_idx_w-1:0]  alu_tag;
  logic [rob_idx_w-1:0]   alu_rob;
  logic [mul_latency-1:0] mul_v;
  logic [data_w-1:0]      mul_p   [mul_latency];
  logic [phys_idx_w-1:0]  mul_tag [mul_latency];
  logic [rob_idx_w-1:0]   mul_rob [mul_latency];

  assign is_mul = (issue_op == exec_mul);

  always_comb begin
    case (issue_op)
      exec_sub: alu_out = issue_a - issue_b;
      exec_and: alu_out = issue_a & issue_b;
      exec_xor: alu_out = issue_a ^ issue_b;
      default:  alu_out = issue_a + issue_b;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      alu_v <= 1'b0;
      mul_v <= '0;
    end else begin
      alu_v <= issue_valid & ~is_mul;
      mul_v <= {mul_v[mul_latency-2:0], issue_valid & is_mul};
    end
  end

  always_ff @(posedge clock) begin
    alu_data   <= alu_out;
    alu_tag    <= issue_tag;
    alu_rob    <= issue_rob;
    mul_p[0]   <= issue_a * issue_b;  // low word only
    mul_tag[0] <= issue_tag;
    mul_rob[0] <= issue_rob;
    for (int i = 1; i < mul_latency; i++) begin
      mul_p[i]   <= mul_p[i-1];
      mul_tag[i] <= mul_tag[i-1];
      mul_rob[i] <= mul_rob[i-1];
    end
  end

  // a multiply one stage from the end owns next cycle's bus
  assign issue_ok  = ~mul_v[mul_latency-2];
  assign res_valid = alu_v | mul_v[mul_latency-1];
  assign res_tag   = mul_v[mul_latency-1] ? mul_tag[mul_latency-1] : alu_tag;
  assign res_data  = mul_v[mul_latency-1] ? mul_p[mul_latency-1]   : alu_data;
  assign res_rob   = mul_v[mul_latency-1] ? mul_rob[mul_latency-1] : alu_rob;

endmodule

// File: design/inst_decoder.sv
////////////////////////////////////////////////////////////
// instruction decoder: opcode to execute op, register
// fields and sign-extended immediate
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module inst_decoder import core_pkg::*; (
  input  inst_word_u            inst_word,
  output exec_op_e              op,
  output logic [arch_idx_w-1:0] dest,
  output logic [arch_idx_w-1:0] src1,
  output logic [arch_idx_w-1:0] src2,
  output logic [data_w-1:0]     imm,
  output logic                  use_imm
);

  logic [data_w-1:0] imm_ext;

  assign imm_ext = {{(data_w-imm_w){inst_word.itype.imm[imm_w-1]}}, inst_word.itype.imm};

  always_comb begin
    dest    = inst_word.rtype.dest;   // dest and src1 sit alike in both views
    src1    = inst_word.rtype.src1;
    src2    = inst_word.rtype.src2;
    op      = exec_add;
    imm     = '0;
    use_imm = 1'b0;
    case (inst_word.rtype.opcode)
      op_sub: op = exec_sub;
      op_and: op = exec_and;
      op_xor: op = exec_xor;
      op_mul: op = exec_mul;
      op_addi: begin
        op      = exec_add;
        imm     = imm_ext;
        use_imm = 1'b1;
      end
      op_xori: begin
        op      = exec_xor;
        imm     = imm_ext;
        use_imm = 1'b1;
      end
      default: op = exec_add;   // op_add and the spare code
    endcase
  end

endmodule

// File: design/ooo_core.sv
////////////////////////////////////////////////////////////
// out-of-order core top: decode, rename, RS, execute,
// result bus and ROB behind a valid/ready dispatch port
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module ooo_core import core_pkg::*; (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  inst_valid,
  input  inst_word_u            inst_word,
  output logic                  inst_ready,
  output logic                  commit_wr_en,
  output logic [arch_idx_w-1:0] commit_wr_idx,
  output logic [data_w-1:0]     commit_wr_data
);

  // decode
  exec_op_e              op;
  logic [arch_idx_w-1:0] dest, src1, src2;
  logic [data_w-1:0]     imm;
  logic                  use_imm;
  // rename and operands
  logic [phys_idx_w-1:0] src1_tag, src2_tag, new_tag, old_tag, free_tag;
  logic                  free_empty, free_valid, rs_full, rob_full, dispatch;
  logic                  rd_ready1, rd_ready2;
  logic [data_w-1:0]     rd_data1, rd_data2;
  logic [rob_idx_w-1:0]  disp_rob;
  // issue and result bus
  logic                  issue_ok, issue_valid, res_valid;
  exec_op_e              issue_op;
  logic [data_w-1:0]     issue_a, issue_b, res_data;
  logic [phys_idx_w-1:0] issue_tag, res_tag;
  logic [rob_idx_w-1:0]  issue_rob, res_rob;

  ////////////////////////////////////////////////////////////
  // dispatch handshake
  assign inst_ready = ~rob_full & ~rs_full & ~free_empty;
  assign dispatch   = inst_valid & inst_ready;

  inst_decoder i_inst_decoder (
    .inst_word (inst_word),
    .op        (op),
    .dest      (dest),
    .src1      (src1),
    .src2      (src2),
    .imm       (imm),
    .use_imm   (use_imm)
  );

  rename_table i_rename_table (
    .clock      (clock),
    .reset      (reset),
    .dispatch   (dispatch),
    .dest       (dest),
    .src1       (src1),
    .src2       (src2),
    .src1_tag   (src1_tag),
    .src2_tag   (src2_tag),
    .new_tag    (new_tag),
    .old_tag    (old_tag),
    .free_empty (free_empty),
    .free_valid (free_valid),
    .free_tag   (free_tag)
  );

  phys_regfile i_phys_regfile (
    .clock       (clock),
    .reset       (reset),
    .alloc_valid (dispatch),
    .alloc_tag   (new_tag),
    .rd_tag1     (src1_tag),
    .rd_tag2     (src2_tag),
    .rd_ready1   (rd_ready1),
    .rd_ready2   (rd_ready2),
    .rd_data1    (rd_data1),
    .rd_data2    (rd_data2),
    .res_valid   (res_valid),
    .res_tag     (res_tag),
    .res_data    (res_data)
  );

  reservation_station i_reservation_station (
    .clock       (clock),
    .reset       (reset),
    .dispatch    (dispatch),
    .op          (op),
    .imm         (imm),
    .use_imm     (use_imm),
    .src1_tag    (src1_tag),
    .src2_tag    (src2_tag),
    .new_tag     (new_tag),
    .rd_ready1   (rd_ready1),
    .rd_ready2   (rd_ready2),
    .rd_data1    (rd_data1),
    .rd_data2    (rd_data2),
    .disp_rob    (disp_rob),
    .rs_full     (rs_full),
    .res_valid   (res_valid),
    .res_tag     (res_tag),
    .res_data    (res_data),
    .issue_ok    (issue_ok),
    .issue_valid (issue_valid),
    .issue_op    (issue_op),
    .issue_a     (issue_a),
    .issue_b     (issue_b),
    .issue_tag   (issue_tag),
    .issue_rob   (issue_rob)
  );

  exec_unit i_exec_unit (
    .clock       (clock),
    .reset       (reset),
    .issue_valid (issue_valid),
    .issue_op    (issue_op),
    .issue_a     (issue_a),
    .issue_b     (issue_b),
    .issue_tag   (issue_tag),
    .issue_rob   (issue_rob),
    .issue_ok    (issue_ok),
    .res_valid   (res_valid),
    .res_tag     (res_tag),
    .res_data    (res_data),
    .res_rob     (res_rob)
  );

  reorder_buffer i_reorder_buffer (
    .clock          (clock),
    .reset          (reset),
    .dispatch       (dispatch),
    .dest           (dest),
    .new_tag        (new_tag),
    .old_tag        (old_tag),
    .disp_rob       (disp_rob),
    .rob_full       (rob_full),
    .res_valid      (res_valid),
    .res_rob        (res_rob),
    .res_data       (res_data),
    .commit_wr_en   (commit_wr_en),
    .commit_wr_idx  (commit_wr_idx),
    .commit_wr_data (commit_wr_data),
    .free_valid     (free_valid),
    .free_tag       (free_tag)
  );

endmodule

// File: design/phys_regfile.sv
////////////////////////////////////////////////////////////
// physical register file: values and ready bits, written
// from the result bus with same-cycle forwarding
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module phys_regfile import core_pkg::*; (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  alloc_valid,
  input  logic [phys_idx_w-1:0] alloc_tag,
  input  logic [phys_idx_w-1:0] rd_tag1,
  input  logic [phys_idx_w-1:0] rd_tag2,
  output logic                  rd_ready1,
  output logic                  rd_ready2,
  output logic [data_w-1:0]     rd_data1,
  output logic [data_w-1:0]     rd_data2,
  input  logic                  res_valid,
  input  logic [phys_idx_w-1:0] res_tag,
  input  logic [data_w-1:0]     res_data
);

  logic [data_w-1:0]    value_q [phys_regs];
  logic [phys_regs-1:0] ready_q;
  logic                 hit1, hit2;

  always_ff @(posedge clock) begin
    if (reset) begin
      ready_q <= '1;   // everything zero and ready
      for (int i = 0; i < phys_regs; i++) begin
        value_q[i] <= '0;
      end
    end else begin
      if (alloc_valid) ready_q[alloc_tag] <= 1'b0;  // pending until its result
      if (res_valid) begin
        ready_q[res_tag] <= 1'b1;
        value_q[res_tag] <= res_data;
      end
    end
  end

  // bypass the result being written this cycle
  assign hit1      = res_valid && (res_tag == rd_tag1);
  assign hit2      = res_valid && (res_tag == rd_tag2);
  assign rd_ready1 = ready_q[rd_tag1] | hit1;
  assign rd_ready2 = ready_q[rd_tag2] | hit2;
  assign rd_data1  = hit1 ? res_data : value_q[rd_tag1];
  assign rd_data2  = hit2 ? res_data : value_q[rd_tag2];

endmodule

// File: design/rename_table.sv
////////////////////////////////////////////////////////////
// rename table: arch to phys map plus circular free list
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module rename_table import core_pkg::*; (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  dispatch,
  input  logic [arch_idx_w-1:0] dest,
  input  logic [arch_idx_w-1:0] src1,
  input  logic [arch_idx_w-1:0] src2,
  output logic [phys_idx_w-1:0] src1_tag,
  output logic [phys_idx_w-1:0] src2_tag,
  output logic [phys_idx_w-1:0] new_tag,
  output logic [phys_idx_w-1:0] old_tag,
  output logic                  free_empty,
  input  logic                  free_valid,
  input  logic [phys_idx_w-1:0] free_tag
);

  logic [phys_idx_w-1:0] map_q  [arch_regs];
  logic [phys_idx_w-1:0] free_q [free_depth];
  logic [free_idx_w-1:0] head, tail;
  logic [free_cnt_w-1:0] count;

  // lookups read the map as it stood before this dispatch
  assign src1_tag   = map_q[src1];
  assign src2_tag   = map_q[src2];
  assign old_tag    = map_q[dest];
  assign new_tag    = free_q[head];
  assign free_empty = (count == '0);

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < arch_regs; i++) begin
        map_q[i] <= phys_idx_w'(i);               // identity map
      end
      for (int i = 0; i < free_depth; i++) begin
        free_q[i] <= phys_idx_w'(arch_regs + i);  // upper tags free
      end
      head  <= '0;
      tail  <= '0;
      count <= free_cnt_w'(free_depth);
    end else begin
      if (dispatch) begin
        map_q[dest] <= new_tag;
        head        <= head + 1'b1;  // pop
      end
      if (free_valid) begin
        free_q[tail] <= free_tag;    // push retired mapping
        tail         <= tail + 1'b1;
      end
      // pop and push together leave count alone
      count <= count + free_cnt_w'(free_valid) - free_cnt_w'(dispatch);
    end
  end

endmodule

// File: design/reorder_buffer.sv
////////////////////////////////////////////////////////////
// reorder buffer: in-order retire of completed results,
// releases the replaced physical tag
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module reorder_buffer import core_pkg::*; (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  dispatch,
  input  logic [arch_idx_w-1:0] dest,
  input  logic [phys_idx_w-1:0] new_tag,
  input  logic [phys_idx_w-1:0] old_tag,
  output logic [rob_idx_w-1:0]  disp_rob,
  output logic                  rob_full,
  input  logic                  res_valid,
  input  logic [rob_idx_w-1:0]  res_rob,
  input  logic [data_w-1:0]     res_data,
  output logic                  commit_wr_en,
  output logic [arch_idx_w-1:0] commit_wr_idx,
  output logic [data_w-1:0]     commit_wr_data,
  output logic                  free_valid,
  output logic [phys_idx_w-1:0] free_tag
);

  logic [rob_depth-1:0]  done;
  logic [arch_idx_w-1:0] dest_q  [rob_depth];
  logic [phys_idx_w-1:0] old_q   [rob_depth];
  logic [data_w-1:0]     value_q [rob_depth];
  logic [rob_idx_w-1:0]  head, tail;
  logic [rob_cnt_w-1:0]  count;
  logic                  retire;

  assign disp_rob = tail;
  assign rob_full = (count == rob_cnt_w'(rob_depth));
  assign retire   = (count != '0) && done[head];

  ////////////////////////////////////////////////////////////
  // pointers and completion
  always_ff @(posedge clock) begin
    if (reset) begin
      done  <= '0;
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (dispatch) begin
        done[tail] <= 1'b0;
        tail       <= tail + 1'b1;
      end
      if (res_valid) done[res_rob] <= 1'b1;  // never the entry being allocated
      if (retire) head <= head + 1'b1;
      count <= count + rob_cnt_w'(dispatch) - rob_cnt_w'(retire);
    end
  end

  // per-entry payload
  always_ff @(posedge clock) begin
    if (dispatch) begin
      dest_q[tail] <= dest;
      old_q[tail]  <= old_tag;
    end
    if (res_valid) value_q[res_rob] <= res_data;  // own copy for commit
  end

  ////////////////////////////////////////////////////////////
  // commit port, one per cycle at most
  assign commit_wr_en   = retire;
  assign commit_wr_idx  = dest_q[head];
  assign commit_wr_data = value_q[head];
  assign free_valid     = retire;         // old mapping goes back to the free list
  assign free_tag       = old_q[head];

endmodule

// File: design/reservation_station.sv
////////////////////////////////////////////////////////////
// reservation station: compacting queue, slot 0 oldest,
// result bus wakeup and oldest-ready issue
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module reservation_station import core_pkg::*; (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  dispatch,
  input  exec_op_e              op,
  input  logic [data_w-1:0]     imm,
  input  logic                  use_imm,
  input  logic [phys_idx_w-1:0] src1_tag,
  input  logic [phys_idx_w-1:0] src2_tag,
  input  logic [phys_idx_w-1:0] new_tag,
  input  logic                  rd_ready1,
  input  logic                  rd_ready2,
  input  logic [data_w-1:0]     rd_data1,
  input  logic [data_w-1:0]     rd_data2,
  input  logic [rob_idx_w-1:0]  disp_rob,
  output logic                  rs_full,
  input  logic                  res_valid,
  input  logic [phys_idx_w-1:0] res_tag,
  input  logic [data_w-1:0]     res_data,
  input  logic                  issue_ok,
  output logic                  issue_valid,
  output exec_op_e              issue_op,
  output logic [data_w-1:0]     issue_a,
  output logic [data_w-1:0]     issue_b,
  output logic [phys_idx_w-1:0] issue_tag,
  output logic [rob_idx_w-1:0]  issue_rob
);

  logic [rs_depth-1:0]   valid, a_rdy, b_rdy;
  exec_op_e              op_q   [rs_depth];
  logic [data_w-1:0]     a_q    [rs_depth];
  logic [data_w-1:0]     b_q    [rs_depth];
  logic [phys_idx_w-1:0] tag_a  [rs_depth];
  logic [phys_idx_w-1:0] tag_b  [rs_depth];
  logic [phys_idx_w-1:0] dst_q  [rs_depth];
  logic [rob_idx_w-1:0]  rob_q  [rs_depth];
  logic [rs_cnt_w-1:0]   count;

  logic [rs_depth-1:0]   a_rdy_w, b_rdy_w, ready;
  logic [data_w-1:0]     a_w    [rs_depth];
  logic [data_w-1:0]     b_w    [rs_depth];
  logic [rs_idx_w-1:0]   sel, wr_slot;
  logic                  fire;

  ////////////////////////////////////////////////////////////
  // wakeup and select
  always_comb begin
    sel = '0;
    for (int i = rs_depth - 1; i >= 0; i--) begin
      a_rdy_w[i] = a_rdy[i] | (res_valid && tag_a[i] == res_tag);
      b_rdy_w[i] = b_rdy[i] | (res_valid && tag_b[i] == res_tag);
      a_w[i]     = a_rdy[i] ? a_q[i] : res_data;  // only kept once tag matched
      b_w[i]     = b_rdy[i] ? b_q[i] : res_data;
      ready[i]   = valid[i] & a_rdy[i] & b_rdy[i];
      if (ready[i]) sel = rs_idx_w'(i);           // lowest slot wins, oldest
    end
  end

  assign fire    = issue_ok && (|ready);
  assign wr_slot = rs_idx_w'(count - rs_cnt_w'(fire));  // first free after compaction
  assign rs_full = (count == rs_cnt_w'(rs_depth));

  assign issue_valid = fire;
  assign issue_op    = op_q[sel];
  assign issue_a     = a_q[sel];
  assign issue_b     = b_q[sel];
  assign issue_tag   = dst_q[sel];
  assign issue_rob   = rob_q[sel];

  ////////////////////////////////////////////////////////////
  // shift down over the issued slot, then append
  always_ff @(posedge clock) begin
    int j;
    if (reset) begin
      valid <= '0;
      count <= '0;
    end else begin
      for (int i = 0; i < rs_depth; i++) begin
        j = (fire && i >= sel && i < rs_depth - 1) ? i + 1 : i;
        valid[i] <= valid[j] && !(fire && i == rs_depth - 1);  // top empties on issue
        a_rdy[i] <= a_rdy_w[j];
        b_rdy[i] <= b_rdy_w[j];
        op_q[i]  <= op_q[j];
        a_q[i]   <= a_w[j];
        b_q[i]   <= b_w[j];
        tag_a[i] <= tag_a[j];
        tag_b[i] <= tag_b[j];
        dst_q[i] <= dst_q[j];
        rob_q[i] <= rob_q[j];
      end
      if (dispatch) begin
        valid[wr_slot] <= 1'b1;
        op_q[wr_slot]  <= op;
        a_q[wr_slot]   <= rd_data1;
        a_rdy[wr_slot] <= rd_ready1;
        tag_a[wr_slot] <= src1_tag;
        b_q[wr_slot]   <= use_imm ? imm : rd_data2;  // immediate rides as operand b
        b_rdy[wr_slot] <= use_imm | rd_ready2;
        tag_b[wr_slot] <= src2_tag;
        dst_q[wr_slot] <= new_tag;
        rob_q[wr_slot] <= disp_rob;
      end
      count <= count + rs_cnt_w'(dispatch) - rs_cnt_w'(fire);
    end
  end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f all.f --top-module ooo_core_tb \
  --Mdir obj_dir -o sim_ooo_core
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

output=$(./obj_dir/sim_ooo_core 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation returned status $status"
  exit 1
fi

if echo "$output" | grep -qx "Test OK"; then
  exit 0
fi
exit 1

// File: test/ooo_core_tb.sv
////////////////////////////////////////////////////////////
// testbench for the out-of-order core: directed and LFSR
// streams checked in order against an ISA model
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module ooo_core_tb import core_pkg::*; ();

  localparam int n_chain  = 9;
  localparam int n_order  = 6;
  localparam int n_mulrun = 14;   // two setup addi plus twelve mul
  localparam int n_random = 300;
  localparam int n_insts  = n_chain + n_order + n_mulrun + n_random;
  localparam int timeout_cycles = (n_insts + 20) * 16;

  logic        clock, reset, inst_valid, inst_ready;
  logic [31:0] inst_word;
  logic        commit_wr_en;
  logic [2:0]  commit_wr_idx;
  logic [31:0] commit_wr_data;

  logic [31:0] lfsr = 32'h47bc_ced9;
  logic [31:0] arch_model [8];     // in-order register state
  logic [31:0] expect_q [$];       // accepted words, oldest first
  logic [7:0]  op_seen = '0;
  int          sent_count = 0, commit_count = 0, fail_count = 0;
  logic        stall_seen = 1'b0;

  ooo_core i_ooo_core (
    .clock          (clock),
    .reset          (reset),
    .inst_valid     (inst_valid),
    .inst_word      (inst_word),
    .inst_ready     (inst_ready),
    .commit_wr_en   (commit_wr_en),
    .commit_wr_idx  (commit_wr_idx),
    .commit_wr_data (commit_wr_data)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;   // 4 ns period
  end

  ////////////////////////////////////////////////////////////
  // helpers
  task automatic report_failure(input string why);
    fail_count++;
    $display("%s", why);
    $display("Test FAILED");
    $fatal(1);
  endtask

  // fibonacci lfsr, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic logic [31:0] enc_r(input logic [2:0] op, input logic [2:0] d,
                                        input logic [2:0] s1, input logic [2:0] s2);
    return {op, d, s1, s2, 20'h0};
  endfunction

  function automatic logic [31:0] enc_i(input logic [2:0] op, input logic [2:0] d,
                                        input logic [2:0] s1, input logic [15:0] imm);
    return {op, d, s1, 7'h0, imm};
  endfunction

  // isa semantics on the architectural model
  function automatic logic [31:0] model_result(input logic [31:0] word);
    logic [31:0] a, b, simm;
    a    = arch_model[word[25:23]];
    b    = arch_model[word[22:20]];
    simm = {{16{word[15]}}, word[15:0]};
    case (word[31:29])
      op_sub:  return a - b;
      op_and:  return a & b;
      op_xor:  return a ^ b;
      op_addi: return a + simm;
      op_xori: return a ^ simm;
      op_mul:  return a * b;          // low 32 bits
      default: return a + b;
    endcase
  endfunction

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clock);
      #1;
    end
  endtask

  // hold word until accepted, ready sampled mid-cycle
  task automatic send_inst(input logic [31:0] word);
    logic taken;
    taken      = 1'b0;
    inst_valid = 1'b1;
    inst_word  = word;
    while (!taken) begin
      @(negedge clock);
      if (inst_ready) begin
        taken = 1'b1;
        expect_q.push_back(word);
        sent_count++;
        op_seen[word[31:29]] = 1'b1;
      end else begin
        stall_seen = 1'b1;
      end
      @(posedge clock);
      #1;
    end
    inst_valid = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // commit comparator
  always @(negedge clock) begin
    logic [31:0] word, exp_data;
    logic [2:0]  exp_idx;
    if (!reset && commit_wr_en) begin
      if (expect_q.size() == 0) begin
        report_failure("commit seen with no instruction outstanding");
      end else begin
        word     = expect_q.pop_front();
        exp_idx  = word[28:26];
        exp_data = model_result(word);
        assert (commit_wr_idx == exp_idx) else
          report_failure($sformatf("FAIL commit_wr_idx got %h expected %h",
                                   commit_wr_idx, exp_idx));
        assert (commit_wr_data == exp_data) else
          report_failure($sformatf("FAIL commit_wr_data got %h expected %h",
                                   commit_wr_data, exp_data));
        arch_model[exp_idx] = exp_data;
        commit_count++;
      end
    end
  end

  initial begin
    repeat (timeout_cycles) @(posedge clock);
    report_failure("timeout while waiting for all instructions to commit");
  end

  ////////////////////////////////////////////////////////////
  // stimulus
  initial begin
    logic [31:0] bits, rest, gap;
    reset      = 1'b1;
    inst_valid = 1'b0;
    inst_word  = '0;
    for (int i = 0; i < 8; i++) arch_model[i] = '0;
    repeat (10) @(posedge clock);
    #1 reset = 1'b0;

    // idle core after reset, stray commits caught by comparator
    idle_cycles(4);
    @(negedge clock);
    assert (inst_ready) else report_failure("inst_ready is low after reset");
    @(posedge clock);
    #1;

    // dependent alu chain
    send_inst(enc_i(op_addi, 3'd1, 3'd0, 16'h0005));
    send_inst(enc_i(op_addi, 3'd2, 3'd1, 16'hfffd));
    send_inst(enc_r(op_add,  3'd3, 3'd1, 3'd2));
    send_inst(enc_r(op_sub,  3'd4, 3'd3, 3'd1));
    send_inst(enc_r(op_add,  3'd1, 3'd4, 3'd4));
    send_inst(enc_r(op_sub,  3'd5, 3'd0, 3'd1));
    send_inst(enc_i(op_addi, 3'd5, 3'd5, 16'h7fff));
    send_inst(enc_i(op_xori, 3'd6, 3'd5, 16'h00ff));
    send_inst(enc_r(op_and,  3'd7, 3'd6, 3'd3));

    // mul overtaken by younger alu ops
    send_inst(enc_i(op_addi, 3'd2, 3'd0, 16'h1234));
    send_inst(enc_r(op_mul,  3'd3, 3'd2, 3'd2));
    send_inst(enc_r(op_add,  3'd4, 3'd1, 3'd1));
    send_inst(enc_r(op_xor,  3'd5, 3'd1, 3'd2));
    send_inst(enc_r(op_sub,  3'd6, 3'd2, 3'd1));
    send_inst(enc_r(op_and,  3'd7, 3'd2, 3'd1));

    // dependent mul run, window fills up
    stall_seen = 1'b0;
    send_inst(enc_i(op_addi, 3'd1, 3'd0, 16'h0003));
    send_inst(enc_i(op_addi, 3'd2, 3'd0, 16'hfff9));
    repeat (12) send_inst(enc_r(op_mul, 3'd1, 3'd1, 3'd2));
    assert (stall_seen) else report_failure("inst_ready never dropped in mul run");

    // random stream with valid gaps
    op_seen = '0;                     // coverage of the random part only
    for (int k = 0; k < n_random; k++) begin
      gap = rand_bits(2);
      if (gap[1:0] == 2'd0) begin
        gap = rand_bits(2);
        idle_cycles(gap + 1);
      end
      bits = rand_bits(3);
      while (bits[2:0] == 3'd7) bits = rand_bits(3);   // spare code unused
      rest = rand_bits(29);
      send_inst({bits[2:0], rest[28:0]});
    end

    wait (commit_count == sent_count);
    idle_cycles(10);                  // no late commits
    assert (&op_seen[6:0]) else report_failure("not every opcode was sent");

    if (fail_count == 0) begin
      $display("Test OK");
      $finish;
    end else begin
      $display("Test FAILED");
      $fatal(1);
    end
  end

endmodule
